/* compile.f */
logic/ym_timer_pkg.sv
logic/slot_counter.sv
logic/write_sequencer.sv
logic/timer_control.sv
logic/timer_unit.sv
logic/ym_timer_top.sv
verification/ym_timer_tb.sv

/* logic/slot_counter.sv */
// Prescaler and operator slot counter; makes clk_en and the once-per-sample zero pulse
module slot_counter (
    input  logic clk,
    input  logic reset,
    output logic clk_en,
    output logic zero
);

    logic [ym_timer_pkg::PRESCALE_W-1:0] pre_cnt;
    logic [ym_timer_pkg::SLOT_W-1:0]     slot;
    logic                                pre_wrap;
    logic                                slot_wrap;

    assign pre_wrap  = (pre_cnt == ym_timer_pkg::PRESCALE_LAST);
    assign slot_wrap = (slot == ym_timer_pkg::SLOT_LAST);

    // clk divider, clk_en is registered so it lands one cycle after the wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            pre_cnt <= '0;
            clk_en  <= 1'b0;
        end else begin
            clk_en <= pre_wrap;
            if (pre_wrap) begin
                pre_cnt <= '0;
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

    // Slot count moves on clk_en
    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= '0;
            zero <= 1'b0;
        end else begin
            // Marks the clk_en cycle that takes slot 23 back to 0
            zero <= pre_wrap && slot_wrap;
            if (clk_en) begin
                if (slot_wrap) begin
                    slot <= '0;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/timer_control.sv */
// Timer register file: decodes host writes, drives both timers, builds status byte and irq_n
module timer_control (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               reg_we,
    input  logic [ym_timer_pkg::BUS_W-1:0]     reg_sel,
    input  logic [ym_timer_pkg::BUS_W-1:0]     reg_data,
    input  logic                               busy,
    input  logic                               flag_a,
    input  logic                               flag_b,
    output logic [ym_timer_pkg::TIMER_A_W-1:0] value_a,
    output logic [ym_timer_pkg::TIMER_B_W-1:0] value_b,
    output logic                               load_a,
    output logic                               load_b,
    output logic                               flag_en_a,
    output logic                               flag_en_b,
    output logic                               clr_flag_a,
    output logic                               clr_flag_b,
    output logic [ym_timer_pkg::BUS_W-1:0]     dout,
    output logic                               irq_n
);

    logic [ym_timer_pkg::BUS_W-1:0] status;

    // Register writes
    always_ff @(posedge clk) begin
        if (reset) begin
            value_a    <= '0;
            value_b    <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            flag_en_a  <= 1'b0;
            flag_en_b  <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
        end else begin
            // Clear requests last one cycle only
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            if (reg_we) begin
                case (reg_sel)
                    ym_timer_pkg::reg_timer_a_hi: begin
                        value_a[ym_timer_pkg::TIMER_A_W-1:2] <= reg_data;
                    end
                    ym_timer_pkg::reg_timer_a_lo: begin
                        value_a[1:0] <= reg_data[1:0];
                    end
                    ym_timer_pkg::reg_timer_b: begin
                        value_b <= reg_data;
                    end
                    ym_timer_pkg::reg_timer_ctl: begin
                        load_a     <= reg_data[ym_timer_pkg::CTL_LOAD_A];
                        load_b     <= reg_data[ym_timer_pkg::CTL_LOAD_B];
                        flag_en_a  <= reg_data[ym_timer_pkg::CTL_EN_A];
                        flag_en_b  <= reg_data[ym_timer_pkg::CTL_EN_B];
                        clr_flag_a <= reg_data[ym_timer_pkg::CTL_CLR_A];
                        clr_flag_b <= reg_data[ym_timer_pkg::CTL_CLR_B];
                    end
                    default: ;  // Not a timer register
                endcase
            end
        end
    end

    // Status byte, unused bits read zero
    always_comb begin
        status                           = '0;
        status[ym_timer_pkg::STAT_BUSY]   = busy;
        status[ym_timer_pkg::STAT_FLAG_B] = flag_b;
        status[ym_timer_pkg::STAT_FLAG_A] = flag_a;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dout <= '0;
        end else begin
            dout <= status;
        end
    end

    // Open-drain style interrupt, low while any flag is up
    assign irq_n = !(flag_a || flag_b);

endmodule

/* logic/timer_unit.sv */
// One FM chip timer: zero-paced up-counter with reload, pre-divider and sticky overflow flag
module timer_unit #(
    parameter int CNT_W   = 10,
    parameter int PRE_DIV = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             zero,
    input  logic [CNT_W-1:0] value,
    input  logic             load,
    input  logic             flag_en,
    input  logic             clr_flag,
    output logic             flag
);

    localparam int PRE_W = $clog2(PRE_DIV + 1);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(PRE_DIV - 1);

    logic [CNT_W-1:0] cnt;
    logic [PRE_W-1:0] pre;
    logic             load_d;
    logic             load_rise;
    logic             step;
    logic             overflow;

    assign load_rise = load && !load_d;
    assign step      = load && !load_rise && zero && (pre == PRE_LAST);
    assign overflow  = step && (&cnt);  // Stepping out of all ones

    always_ff @(posedge clk) begin
        if (reset) begin
            load_d <= 1'b0;
            pre    <= '0;
            cnt    <= '0;
        end else begin
            load_d <= load;
            if (load_rise) begin
                pre <= '0;
                cnt <= value;
            end else if (load && zero) begin
                if (pre == PRE_LAST) begin
                    pre <= '0;
                end else begin
                    pre <= pre + 1'b1;
                end
                if (step) begin
                    cnt <= overflow ? value : cnt + 1'b1;  // Reload on wrap
                end
            end
        end
    end

    // Sticky flag, a new overflow wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            flag <= 1'b0;
        end else if (overflow && flag_en) begin
            flag <= 1'b1;
        end else if (clr_flag) begin
            flag <= 1'b0;
        end
    end

endmodule

/* logic/write_sequencer.sv */
// Host write port decoder: address latch, data write forwarding and the busy window
module write_sequencer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           clk_en,
    input  logic                           cs_n,
    input  logic                           wr_n,
    input  logic [1:0]                     addr,
    input  logic [ym_timer_pkg::BUS_W-1:0] din,
    output logic                           reg_we,
    output logic [ym_timer_pkg::BUS_W-1:0] reg_sel,
    output logic [ym_timer_pkg::BUS_W-1:0] reg_data,
    output logic                           busy
);

    ym_timer_pkg::seq_state_e        state;
    logic [ym_timer_pkg::BUSY_W-1:0] busy_cnt;  // clk_en pulses seen while busy
    logic                            write;
    logic                            addr_write;
    logic                            data_write;
    logic                            bank0;

    assign write      = !cs_n && !wr_n;
    assign addr_write = write && !addr[ym_timer_pkg::ADDR_DATA_BIT];
    assign data_write = write && addr[ym_timer_pkg::ADDR_DATA_BIT];
    assign bank0      = !addr[ym_timer_pkg::ADDR_BANK_BIT];

    assign busy = (state == ym_timer_pkg::seq_busy);

    // Address latch takes every address write, busy or not
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_sel <= '0;
        end else if (addr_write) begin
            reg_sel <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ym_timer_pkg::seq_idle;
            busy_cnt <= '0;
            reg_we   <= 1'b0;
        end else begin
            reg_we <= 1'b0;
            case (state)
                ym_timer_pkg::seq_idle: begin
                    if (data_write) begin
                        reg_we   <= bank0;  // Bank 1 only costs a busy period
                        busy_cnt <= '0;
                        state    <= ym_timer_pkg::seq_busy;
                    end
                end
                ym_timer_pkg::seq_busy: begin
                    // Data writes here are simply lost
                    if (clk_en) begin
                        if (busy_cnt == ym_timer_pkg::BUSY_LAST) begin
                            state <= ym_timer_pkg::seq_idle;
                        end else begin
                            busy_cnt <= busy_cnt + 1'b1;
                        end
                    end
                end
                default: state <= ym_timer_pkg::seq_idle;
            endcase
        end
    end

    // Data byte goes out with reg_we
    always_ff @(posedge clk) begin
        if (data_write && !busy) begin
            reg_data <= din;
        end
    end

endmodule

/* logic/ym_timer_pkg.sv */
// Shared constants and encodings for the FM chip timer block, referenced as ym_timer_pkg::name
package ym_timer_pkg;

    // Clocking and sample cycle
    localparam int PRESCALE_DIV = 6;   // clk cycles per clk_en
    localparam int SLOT_COUNT   = 24;  // Operator slots per sample
    localparam int PRESCALE_W   = $clog2(PRESCALE_DIV);
    localparam int SLOT_W       = $clog2(SLOT_COUNT);
    localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(PRESCALE_DIV - 1);
    localparam logic [SLOT_W-1:0]     SLOT_LAST     = SLOT_W'(SLOT_COUNT - 1);

    // Host bus
    localparam int BUS_W         = 8;
    localparam int ADDR_DATA_BIT = 0;  // Set for data writes, clear for address writes
    localparam int ADDR_BANK_BIT = 1;  // Bank 1 when set

    // Busy window after a data write, in clk_en pulses
    localparam int BUSY_TICKS = 32;
    localparam int BUSY_W     = $clog2(BUSY_TICKS);
    localparam logic [BUSY_W-1:0] BUSY_LAST = BUSY_W'(BUSY_TICKS - 1);

    // Timers
    localparam int TIMER_A_W   = 10;
    localparam int TIMER_B_W   = 8;
    localparam int TIMER_B_PRE = 16;  // zero pulses per Timer B step

    // Bits of the timer control register
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_EN_A   = 2;
    localparam int CTL_EN_B   = 3;
    localparam int CTL_CLR_A  = 4;
    localparam int CTL_CLR_B  = 5;

    // Status byte layout
    localparam int STAT_FLAG_A = 0;
    localparam int STAT_FLAG_B = 1;
    localparam int STAT_BUSY   = BUS_W - 1;

    typedef enum logic [0:0] {
        seq_idle = 1'b0,
        seq_busy = 1'b1
    } seq_state_e;

    typedef enum logic [7:0] {
        reg_timer_a_hi = 8'h24,  // Timer A bits 9..2
        reg_timer_a_lo = 8'h25,  // Timer A bits 1..0
        reg_timer_b    = 8'h26,
        reg_timer_ctl  = 8'h27
    } reg_addr_e;

endpackage

/* logic/ym_timer_top.sv */
// Top level of the timer and host interface block; connects prescaler, bus sequencer and timers
module ym_timer_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cs_n,
    input  logic                           wr_n,
    input  logic [1:0]                     addr,
    input  logic [ym_timer_pkg::BUS_W-1:0] din,
    output logic [ym_timer_pkg::BUS_W-1:0] dout,
    output logic                           irq_n
);

    logic clk_en;
    logic zero;  // One pulse per sample cycle

    // Register write path
    logic                           reg_we;
    logic [ym_timer_pkg::BUS_W-1:0] reg_sel;
    logic [ym_timer_pkg::BUS_W-1:0] reg_data;
    logic                           busy;

    // Timer settings and flags
    logic [ym_timer_pkg::TIMER_A_W-1:0] value_a;
    logic [ym_timer_pkg::TIMER_B_W-1:0] value_b;
    logic load_a, load_b;
    logic flag_en_a, flag_en_b;
    logic clr_flag_a, clr_flag_b;
    logic flag_a, flag_b;

    slot_counter u_slot (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .zero   (zero)
    );

    write_sequencer u_seq (
        .clk      (clk),
        .reset    (reset),
        .clk_en   (clk_en),
        .cs_n     (cs_n),
        .wr_n     (wr_n),
        .addr     (addr),
        .din      (din),
        .reg_we   (reg_we),
        .reg_sel  (reg_sel),
        .reg_data (reg_data),
        .busy     (busy)
    );

    timer_control u_ctl (
        .clk        (clk),
        .reset      (reset),
        .reg_we     (reg_we),
        .reg_sel    (reg_sel),
        .reg_data   (reg_data),
        .busy       (busy),
        .flag_a     (flag_a),
        .flag_b     (flag_b),
        .value_a    (value_a),
        .value_b    (value_b),
        .load_a     (load_a),
        .load_b     (load_b),
        .flag_en_a  (flag_en_a),
        .flag_en_b  (flag_en_b),
        .clr_flag_a (clr_flag_a),
        .clr_flag_b (clr_flag_b),
        .dout       (dout),
        .irq_n      (irq_n)
    );

    // Timer A steps on every zero pulse
    timer_unit #(.CNT_W(ym_timer_pkg::TIMER_A_W), .PRE_DIV(1)) u_timer_a (
        .clk      (clk),
        .reset    (reset),
        .zero     (zero),
        .value    (value_a),
        .load     (load_a),
        .flag_en  (flag_en_a),
        .clr_flag (clr_flag_a),
        .flag     (flag_a)
    );

    timer_unit #(
        .CNT_W   (ym_timer_pkg::TIMER_B_W),
        .PRE_DIV (ym_timer_pkg::TIMER_B_PRE)
    ) u_timer_b (
        .clk      (clk),
        .reset    (reset),
        .zero     (zero),
        .value    (value_b),
        .load     (load_b),
        .flag_en  (flag_en_b),
        .clr_flag (clr_flag_b),
        .flag     (flag_b)
    );

endmodule

/* verification/ym_timer_tb.sv */
// Random-stimulus testbench for ym_timer_top; checks busy, both timers and flags against a model
module ym_timer_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SAMPLE_CYC = 144;  // clk cycles between zero pulses
    localparam int B_PRE      = 16;
    localparam int WIN_A      = (1024 - 1016 + 1) * SAMPLE_CYC + 12;
    localparam int WIN_B      = ((256 - 254) * B_PRE + 1) * SAMPLE_CYC + 12;
    localparam int BUSY_WIN   = 200;
    localparam int BUSY_MIN   = 180;
    localparam int DATA_WRITES = 14;
    localparam int TIMEOUT_CYC = 3 * (BUSY_WIN * DATA_WRITES + 6 * WIN_A + 2 * WIN_B) / 2;

    localparam logic [7:0] ADDR_A_HI = 8'h24;
    localparam logic [7:0] ADDR_A_LO = 8'h25;
    localparam logic [7:0] ADDR_B    = 8'h26;
    localparam logic [7:0] ADDR_CTL  = 8'h27;

    logic       clk;
    logic       reset;
    logic       cs_n;
    logic       wr_n;
    logic [1:0] addr;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq_n;

    int cycles = 0;
    int last_write_cyc;
    int errors;
    int err_mark;
    int tests_run;
    int tests_failed;

    // Reference model state
    logic [9:0] m_val_a;
    logic [7:0] m_val_b;
    logic [7:0] m_sel;     // Latched register address
    logic       m_en_a;
    logic       m_en_b;
    logic       exp_a;     // Expected flags
    logic       exp_b;

    ym_timer_top uut (
        .clk   (clk),
        .reset (reset),
        .cs_n  (cs_n),
        .wr_n  (wr_n),
        .addr  (addr),
        .din   (din),
        .dout  (dout),
        .irq_n (irq_n)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    task report_value(input string name, input int exp, input int act);
        $display("[ERROR] %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
        errors++;
    endtask

    task report_fail(input string msg);
        $display("Failure at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task end_test(input int num, input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endtask

    // Register rules from the timer register map
    task apply_reg(input logic [7:0] sel, input logic [7:0] d);
        case (sel)
            ADDR_A_HI: m_val_a[9:2] = d;
            ADDR_A_LO: m_val_a[1:0] = d[1:0];
            ADDR_B:    m_val_b = d;
            ADDR_CTL: begin
                m_en_a = d[2];
                m_en_b = d[3];
                if (d[4]) exp_a = 1'b0;
                if (d[5]) exp_b = 1'b0;
            end
            default: ;
        endcase
    endtask

    function int period_a();
        return 1024 - int'(m_val_a);
    endfunction

    function int period_b();
        return (256 - int'(m_val_b)) * B_PRE;
    endfunction

    task read_status(output logic [7:0] s);
        @(negedge clk);
        s = dout;
    endtask

    task wait_not_busy();
        logic [7:0] s;
        read_status(s);
        while (s[7]) read_status(s);
    endtask

    task bus_write(input logic [1:0] a, input logic [7:0] d);
        @(negedge clk);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = a;
        din  = d;
        last_write_cyc = cycles;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task write_addr(input logic bank, input logic [7:0] sel);
        bus_write({bank, 1'b0}, sel);
        m_sel = sel;
    endtask

    task write_data(input logic bank, input logic [7:0] d);
        wait_not_busy();
        bus_write({bank, 1'b1}, d);
        if (!bank) apply_reg(m_sel, d);  // Bank 1 holds no registers
    endtask

    // Compares the current flags and irq_n with the model
    task check_flags();
        if (dout[0] !== exp_a) report_value("dout[0]", exp_a, dout[0]);
        if (dout[1] !== exp_b) report_value("dout[1]", exp_b, dout[1]);
        if (irq_n !== !(exp_a || exp_b)) report_value("irq_n", !(exp_a || exp_b), irq_n);
    endtask

    // Overflow window in zero pulses, with one pulse of phase slack either way
    task automatic wait_flag(input int idx, input int t_start, input int pulses,
                             output int t_set);
        int         lo;
        int         hi;
        int         el;
        logic [7:0] s;
        logic       done;
        lo   = (pulses - 1) * SAMPLE_CYC;
        hi   = (pulses + 1) * SAMPLE_CYC + 12;
        done = 1'b0;
        while (!done) begin
            read_status(s);
            el = cycles - t_start;
            if (s[idx]) begin
                if (el < lo) begin
                    report_fail($sformatf("flag %0d set after %0d cycles, before %0d",
                                          idx, el, lo));
                end
                done = 1'b1;
            end else if (el > hi) begin
                report_fail($sformatf("flag %0d not set within %0d cycles", idx, hi));
                done = 1'b1;
            end
        end
        t_set = cycles;
        if (idx == 0) exp_a = m_en_a;  // Overflow raises the flag only when enabled
        else exp_b = m_en_b;
    endtask

    initial begin
        while (cycles < TIMEOUT_CYC) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int         seed_sink;
        int         t0;
        int         t_a;
        int         t_b;
        int         el;
        int         pa_cyc;
        logic [7:0] s;
        logic [7:0] junk;
        logic [9:0] val_a;
        logic       done;

        seed_sink = $urandom(32'h591e);
        clk   = 1'b0;
        reset = 1'b1;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        addr  = 2'd0;
        din   = 8'h00;
        {errors, err_mark, tests_run, tests_failed} = '0;
        m_val_a = '0;
        m_val_b = '0;
        m_sel   = '0;
        {m_en_a, m_en_b, exp_a, exp_b} = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset state and the busy window
        read_status(s);
        if (s !== 8'h00) report_value("dout", 0, s);
        if (irq_n !== 1'b1) report_value("irq_n", 1, irq_n);
        write_addr(1'b0, 8'h30);
        write_data(1'b0, 8'($urandom));
        t0 = last_write_cyc;
        read_status(s);
        if (s[7] !== 1'b1) report_value("dout[7]", 1, s[7]);
        done = 1'b0;
        while (!done) begin
            read_status(s);
            el = cycles - t0;
            if (!s[7]) begin
                done = 1'b1;
            end else if (el > BUSY_WIN) begin
                report_fail("busy still high 200 cycles after the data write");
                done = 1'b1;
            end
        end
        if (!s[7] && el < BUSY_MIN) report_fail($sformatf("busy ended after %0d cycles", el));
        end_test(1, "busy period");

        val_a = 10'(1016 + $urandom % 7);
        write_addr(1'b0, ADDR_A_HI);
        write_data(1'b0, val_a[9:2]);
        write_addr(1'b0, ADDR_A_LO);
        write_data(1'b0, {6'b0, val_a[1:0]});
        write_addr(1'b0, ADDR_CTL);
        write_data(1'b0, 8'h05);
        wait_flag(0, last_write_cyc, period_a(), t_a);
        check_flags();
        end_test(2, "timer A overflow");

        write_addr(1'b0, ADDR_B);
        write_data(1'b0, 8'(254 + $urandom % 2));
        write_addr(1'b0, ADDR_CTL);
        write_data(1'b0, 8'h0F);  // Timer A keeps running
        wait_flag(1, last_write_cyc, period_b(), t_b);
        check_flags();
        end_test(3, "timer B overflow");

        write_addr(1'b0, ADDR_CTL);
        write_data(1'b0, 8'h2F);
        repeat (4) @(negedge clk);
        check_flags();
        wait_flag(1, t_b, period_b(), t_b);
        // Clear A well away from its next overflow
        write_addr(1'b0, ADDR_CTL);
        wait_not_busy();
        pa_cyc = period_a() * SAMPLE_CYC;
        while ((cycles - t_a) % pa_cyc != 20) @(negedge clk);
        bus_write(2'd1, 8'h1F);
        apply_reg(m_sel, 8'h1F);
        t0 = last_write_cyc;
        repeat (4) @(negedge clk);
        check_flags();
        wait_flag(0, t0, period_a(), t_a);
        end_test(4, "flag clear");

        write_addr(1'b0, ADDR_CTL);
        write_data(1'b0, 8'h31);  // A runs with its flag disabled
        repeat (4) @(negedge clk);
        check_flags();
        do junk = 8'($urandom); while (junk >= ADDR_A_HI && junk <= ADDR_CTL);
        write_addr(1'b0, junk);
        write_data(1'b0, 8'($urandom));
        write_addr(1'b1, ADDR_CTL);
        write_data(1'b1, 8'hFF);
        t0 = cycles;
        done = 1'b0;
        while (!done && cycles - t0 < 2 * pa_cyc + SAMPLE_CYC) begin
            read_status(s);
            if (s[1:0] !== {exp_b, exp_a}) begin
                report_value("dout[1:0]", {exp_b, exp_a}, s[1:0]);
                done = 1'b1;
            end
        end
        end_test(5, "disabled flag and ignored writes");

        write_addr(1'b0, ADDR_CTL);
        write_data(1'b0, 8'h00);
        write_addr(1'b0, ADDR_A_HI);
        read_status(s);
        if (!s[7]) report_fail("busy was already low before the write meant to be dropped");
        bus_write(2'd1, 8'($urandom % 128));  // Dropped while busy so the model keeps the old value
        write_addr(1'b0, ADDR_CTL);
        write_data(1'b0, 8'h05);
        wait_flag(0, last_write_cyc, period_a(), t_a);
        check_flags();
        end_test(6, "write dropped while busy");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
